//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_slide_unit
FILELIST  := slide_unit.f
OBJ_DIR   := obj_dir
RUNFLAGS  := +verilator+error+limit+1000
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/result_buffer.sv
`timescale 1ns/1ps

module result_buffer #(
  parameter int unsigned NrLanes     = 2,
  parameter int unsigned ResultDepth = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  res_push_if.receiver push,
  res_head_if.source   head
);
  import slide_pkg::*;

  localparam int unsigned DataW = ElenW * NrLanes;
  localparam int unsigned StrbW = DataW / 8;
  localparam int unsigned PntW  = (ResultDepth > 1) ? $clog2(ResultDepth) : 1;
  localparam int unsigned FillW = $clog2(ResultDepth + 1);

  ////////////////////
  // Entry storage
  ////////////////////

  logic [AddrW-1:0] addr_mem  [ResultDepth];
  logic [DataW-1:0] wdata_mem [ResultDepth];
  logic [StrbW-1:0] be_mem    [ResultDepth];
  logic [IdW-1:0]   id_mem    [ResultDepth];
  logic             last_mem  [ResultDepth];

  logic [PntW-1:0]  wr_pnt_q;
  logic [PntW-1:0]  rd_pnt_q;
  // Entries currently held
  logic [FillW-1:0] fill_q;
  logic             drain;

  // Credits guarantee a free slot, so every push is written
  always_ff @(posedge clk_i) begin
    if (push.push) begin
      addr_mem[wr_pnt_q]  <= push.addr;
      wdata_mem[wr_pnt_q] <= push.wdata;
      be_mem[wr_pnt_q]    <= push.be;
      id_mem[wr_pnt_q]    <= push.id;
      last_mem[wr_pnt_q]  <= push.last;
    end
  end

  ////////////////////
  // Head and credits
  ////////////////////

  assign drain       = head.pop && head.valid;
  // Credit goes back in the cycle the entry drains
  assign push.credit = drain;

  assign head.valid = fill_q != '0;
  assign head.addr  = addr_mem[rd_pnt_q];
  assign head.wdata = wdata_mem[rd_pnt_q];
  assign head.be    = be_mem[rd_pnt_q];
  assign head.id    = id_mem[rd_pnt_q];
  assign head.last  = last_mem[rd_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push.push) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(ResultDepth - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (drain) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(ResultDepth - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      fill_q <= fill_q + FillW'(push.push) - FillW'(drain);
    end
  end

endmodule

//--- hw/slide_if.sv
`timescale 1ns/1ps

// Result pushes from the slide engine into the result buffer
interface res_push_if #(
  parameter int unsigned NrLanes = 2
);
  import slide_pkg::*;

  localparam int unsigned DataW = ElenW * NrLanes;
  localparam int unsigned StrbW = DataW / 8;

  logic             push;
  logic [AddrW-1:0] addr;
  logic [DataW-1:0] wdata;
  logic [StrbW-1:0] be;
  logic [IdW-1:0]   id;
  logic             last;
  // One pulse per drained buffer entry
  logic             credit;

  modport sender (output push, addr, wdata, be, id, last, input credit);
  modport receiver (input push, addr, wdata, be, id, last, output credit);

endinterface

// Oldest buffer entry offered to the write-back port
interface res_head_if #(
  parameter int unsigned NrLanes = 2
);
  import slide_pkg::*;

  localparam int unsigned DataW = ElenW * NrLanes;
  localparam int unsigned StrbW = DataW / 8;

  logic             valid;
  logic [AddrW-1:0] addr;
  logic [DataW-1:0] wdata;
  logic [StrbW-1:0] be;
  logic [IdW-1:0]   id;
  logic             last;
  // Retires the head entry at the clock edge
  logic             pop;

  modport source (output valid, addr, wdata, be, id, last, input pop);
  modport sink (input valid, addr, wdata, be, id, last, output pop);

endinterface

//--- hw/slide_issue.sv
`timescale 1ns/1ps

module slide_issue #(
  parameter int unsigned NrLanes     = 2,
  parameter int unsigned InsnDepth   = 2,
  parameter int unsigned ResultDepth = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  slide_pkg::slide_req_t               req_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [slide_pkg::ElenW*NrLanes-1:0] operand_i,
  input  logic                                operand_valid_i,
  output logic                                operand_ready_o,
  res_push_if.sender                          push
);
  import slide_pkg::*;

  // Word width in bytes and in bits
  localparam int unsigned W           = ElenW * NrLanes / 8;
  localparam int unsigned DataW       = ElenW * NrLanes;
  localparam int unsigned WordsPerReg = VlenB / W;
  localparam int unsigned ByteIdxW    = $clog2(W);
  // Byte pointers must also hold the value W
  localparam int unsigned PntW        = ByteIdxW + 1;
  // Byte counts up to 255 elements of 8 bytes
  localparam int unsigned CntW        = VlW + 3;
  localparam int unsigned QIdxW       = (InsnDepth > 1) ? $clog2(InsnDepth) : 1;
  localparam int unsigned QCntW       = $clog2(InsnDepth + 1);
  localparam int unsigned CredW       = $clog2(ResultDepth + 1);

  ////////////////////
  // Instruction queue
  ////////////////////

  slide_req_t       insn_q [InsnDepth];
  logic [QIdxW-1:0] accept_pnt_q;
  logic [QIdxW-1:0] issue_pnt_q;
  logic [QCntW-1:0] insn_cnt_q;
  logic             accept;
  logic             retire;
  // Instruction at the issue pointer, held in place until it retires
  slide_req_t       cur;

  assign req_ready_o = insn_cnt_q < QCntW'(InsnDepth);
  assign accept      = req_valid_i && req_ready_o;
  assign cur         = insn_q[issue_pnt_q];

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      insn_cnt_q   <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= (accept_pnt_q == QIdxW'(InsnDepth - 1)) ? '0 : accept_pnt_q + 1'b1;
      end
      if (retire) begin
        issue_pnt_q <= (issue_pnt_q == QIdxW'(InsnDepth - 1)) ? '0 : issue_pnt_q + 1'b1;
      end
      insn_cnt_q <= insn_cnt_q + QCntW'(accept) - QCntW'(retire);
    end
  end

  ////////////////////
  // Slide engine
  ////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_finish
  } state_e;

  state_e           state_q, state_d;
  // Byte pointers into the operand word and the staging result word
  logic [PntW-1:0]  in_pnt_q, in_pnt_d;
  logic [PntW-1:0]  out_pnt_q, out_pnt_d;
  // Bytes still to copy
  logic [CntW-1:0]  rem_q, rem_d;
  // Destination word index inside the register
  logic [AddrW-1:0] vrf_pnt_q, vrf_pnt_d;
  logic [DataW-1:0] stage_wdata_q, stage_wdata_d;
  logic [W-1:0]     stage_be_q, stage_be_d;
  logic [CredW-1:0] credit_q;

  logic [CntW-1:0]  byte_cnt;
  logic [CntW-1:0]  byte_off;
  logic             step;
  logic             last_step;
  logic             in_empty;
  logic             out_full;
  logic             push_word;
  logic [PntW-1:0]  in_left;
  logic [PntW-1:0]  out_left;
  logic [PntW-1:0]  step_n;
  logic [W-1:0]     step_be;
  logic [DataW-1:0] step_bits;
  logic [DataW-1:0] placed;
  logic [DataW-1:0] word_wdata;
  logic [W-1:0]     word_be;

  // Element counts turned into byte counts
  assign byte_cnt = CntW'(cur.vl) << cur.vsew;
  assign byte_off = CntW'(cur.stride) << cur.vsew;

  // A step needs an operand and room in the result buffer
  assign step     = (state_q == st_run) && operand_valid_i && (credit_q != '0);
  assign in_left  = PntW'(W) - in_pnt_q;
  assign out_left = PntW'(W) - out_pnt_q;

  // Bytes moved this step, the least of both word remainders and the bytes left
  always_comb begin
    step_n = (in_left < out_left) ? in_left : out_left;
    if (CntW'(step_n) > rem_q) begin
      step_n = PntW'(rem_q);
    end
  end

  assign last_step = CntW'(step_n) == rem_q;
  assign in_empty  = (in_pnt_q + step_n) == PntW'(W);
  assign out_full  = (out_pnt_q + step_n) == PntW'(W);

  // Output bytes written by this step
  always_comb begin
    for (int i = 0; i < W; i++) begin
      step_be[i] = (PntW'(i) >= out_pnt_q) && (PntW'(i) < out_pnt_q + step_n);
      step_bits[8*i +: 8] = {8{step_be[i]}};
    end
  end

  // Align the input bytes to byte 0, then move them up to the output pointer
  assign placed     = (operand_i >> {in_pnt_q, 3'b000}) << {out_pnt_q, 3'b000};
  assign word_wdata = (stage_wdata_q & ~step_bits) | (placed & step_bits);
  assign word_be    = stage_be_q | step_be;

  assign push_word       = step && (out_full || last_step);
  assign operand_ready_o = step && (in_empty || last_step);
  assign retire          = state_q == st_finish;

  assign push.push  = push_word;
  assign push.addr  = AddrW'(cur.vd) * AddrW'(WordsPerReg) + vrf_pnt_q;
  assign push.wdata = word_wdata;
  assign push.be    = word_be;
  assign push.id    = cur.id;
  assign push.last  = last_step;

  always_comb begin
    state_d       = state_q;
    in_pnt_d      = in_pnt_q;
    out_pnt_d     = out_pnt_q;
    rem_d         = rem_q;
    vrf_pnt_d     = vrf_pnt_q;
    stage_wdata_d = stage_wdata_q;
    stage_be_d    = stage_be_q;

    case (state_q)
      st_idle: begin
        if (insn_cnt_q != '0) begin
          stage_wdata_d = '0;
          stage_be_d    = '0;
          if (cur.op == op_slideup) begin
            // Read from source byte 0, write from byte off onward
            in_pnt_d  = '0;
            out_pnt_d = PntW'(byte_off[ByteIdxW-1:0]);
            vrf_pnt_d = AddrW'(byte_off >> ByteIdxW);
            rem_d     = (byte_off < byte_cnt) ? byte_cnt - byte_off : '0;
          end else begin
            // Source stream starts inside word off/W
            in_pnt_d  = PntW'(byte_off[ByteIdxW-1:0]);
            out_pnt_d = '0;
            vrf_pnt_d = '0;
            rem_d     = byte_cnt;
          end
          // Nothing to write means the instruction retires right away
          state_d = (rem_d == '0) ? st_finish : st_run;
        end
      end
      st_run: begin
        if (step) begin
          in_pnt_d      = in_empty ? '0 : in_pnt_q + step_n;
          out_pnt_d     = out_pnt_q + step_n;
          rem_d         = rem_q - CntW'(step_n);
          stage_wdata_d = word_wdata;
          stage_be_d    = word_be;
          if (push_word) begin
            // Word leaves through the push port, start a fresh one
            out_pnt_d     = '0;
            vrf_pnt_d     = vrf_pnt_q + 1'b1;
            stage_wdata_d = '0;
            stage_be_d    = '0;
          end
          if (last_step) begin
            state_d = st_finish;
          end
        end
      end
      // Queue entry is released here
      st_finish: state_d = st_idle;
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      rem_q     <= '0;
      vrf_pnt_q <= '0;
      credit_q  <= CredW'(ResultDepth);
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      rem_q     <= rem_d;
      vrf_pnt_q <= vrf_pnt_d;
      // One credit per push, one back per drained entry
      credit_q  <= credit_q - CredW'(push_word) + CredW'(push.credit);
    end
  end

  always_ff @(posedge clk_i) begin
    stage_wdata_q <= stage_wdata_d;
    stage_be_q    <= stage_be_d;
  end

endmodule

//--- hw/slide_pkg.sv
package slide_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // Lane datapath width in bits
  localparam int unsigned ElenW = 64;
  // Bytes held by one vector register
  localparam int unsigned VlenB = 128;
  // Register file word address width
  localparam int unsigned AddrW = 10;
  // Instruction id width
  localparam int unsigned IdW = 3;
  // Vector length and stride field width
  localparam int unsigned VlW = 8;

  ////////////////////
  // Types
  ////////////////////

  // Element width code, an element holds 2**code bytes
  typedef enum logic [1:0] {
    ew8  = 2'd0,
    ew16 = 2'd1,
    ew32 = 2'd2,
    ew64 = 2'd3
  } vsew_e;

  typedef enum logic {
    op_slideup   = 1'b0,
    op_slidedown = 1'b1
  } slide_op_e;

  // Slide request as queued by the issue stage
  typedef struct packed {
    slide_op_e      op;
    vsew_e          vsew;
    // Length and stride both count elements
    logic [VlW-1:0] vl;
    logic [VlW-1:0] stride;
    logic [4:0]     vd;
    logic [IdW-1:0] id;
  } slide_req_t;

endpackage

//--- hw/slide_unit_top.sv
`timescale 1ns/1ps

module slide_unit_top #(
  parameter int unsigned NrLanes     = 2,
  parameter int unsigned ResultDepth = 2,
  parameter int unsigned InsnDepth   = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Request port
  input  logic                                  req_valid_i,
  output logic                                  req_ready_o,
  input  slide_pkg::slide_op_e                  req_op_i,
  input  slide_pkg::vsew_e                      req_vsew_i,
  input  logic [slide_pkg::VlW-1:0]             req_vl_i,
  input  logic [slide_pkg::VlW-1:0]             req_stride_i,
  input  logic [4:0]                            req_vd_i,
  input  logic [slide_pkg::IdW-1:0]             req_id_i,
  // Source operand stream
  input  logic [slide_pkg::ElenW*NrLanes-1:0]   operand_i,
  input  logic                                  operand_valid_i,
  output logic                                  operand_ready_o,
  // Register file write port
  output logic                                  result_req_o,
  output logic [slide_pkg::AddrW-1:0]           result_addr_o,
  output logic [slide_pkg::ElenW*NrLanes-1:0]   result_wdata_o,
  output logic [slide_pkg::ElenW*NrLanes/8-1:0] result_be_o,
  input  logic                                  result_gnt_i,
  // Completion report
  output logic                                  done_valid_o,
  output logic [slide_pkg::IdW-1:0]             done_id_o
);
  import slide_pkg::*;

  ////////////////////
  // Request packing
  ////////////////////

  slide_req_t req;

  assign req.op     = req_op_i;
  assign req.vsew   = req_vsew_i;
  assign req.vl     = req_vl_i;
  assign req.stride = req_stride_i;
  assign req.vd     = req_vd_i;
  assign req.id     = req_id_i;

  ////////////////////
  // Stages
  ////////////////////

  res_push_if #(.NrLanes(NrLanes)) push_if ();
  res_head_if #(.NrLanes(NrLanes)) head_if ();

  // Queue and slide engine
  slide_issue #(
    .NrLanes    (NrLanes),
    .InsnDepth  (InsnDepth),
    .ResultDepth(ResultDepth)
  ) i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .push           (push_if.sender)
  );

  // Credit-controlled result FIFO
  result_buffer #(
    .NrLanes    (NrLanes),
    .ResultDepth(ResultDepth)
  ) i_buffer (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .push  (push_if.receiver),
    .head  (head_if.source)
  );

  vrf_writeback #(
    .NrLanes(NrLanes)
  ) i_writeback (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head          (head_if.sink),
    .result_req_o  (result_req_o),
    .result_addr_o (result_addr_o),
    .result_wdata_o(result_wdata_o),
    .result_be_o   (result_be_o),
    .result_gnt_i  (result_gnt_i),
    .done_valid_o  (done_valid_o),
    .done_id_o     (done_id_o)
  );

endmodule

//--- hw/vrf_writeback.sv
`timescale 1ns/1ps

module vrf_writeback #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  res_head_if.sink                              head,
  // Register file write port
  output logic                                  result_req_o,
  output logic [slide_pkg::AddrW-1:0]           result_addr_o,
  output logic [slide_pkg::ElenW*NrLanes-1:0]   result_wdata_o,
  output logic [slide_pkg::ElenW*NrLanes/8-1:0] result_be_o,
  input  logic                                  result_gnt_i,
  // Completion report
  output logic                                  done_valid_o,
  output logic [slide_pkg::IdW-1:0]             done_id_o
);

  ////////////////////
  // Write port
  ////////////////////

  logic granted;
  logic granted_last;

  // Head entry drives the port and holds until granted
  assign result_req_o   = head.valid;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  assign granted      = head.valid && result_gnt_i;
  assign granted_last = granted && head.last;
  assign head.pop     = granted;

  ////////////////////
  // Completion
  ////////////////////

  // Pulse one cycle after the last word of an instruction is granted
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_valid_o <= 1'b0;
    end else begin
      done_valid_o <= granted_last;
    end
  end

  // Id only matters while done_valid_o is high
  always_ff @(posedge clk_i) begin
    if (granted_last) begin
      done_id_o <= head.id;
    end
  end

endmodule

//--- slide_unit.f
hw/slide_pkg.sv
hw/slide_if.sv
hw/slide_issue.sv
hw/result_buffer.sv
hw/vrf_writeback.sv
hw/slide_unit_top.sv
tb/slide_unit_checker.sv
tb/tb_slide_unit.sv

//--- tb/slide_unit_checker.sv
`timescale 1ns/1ps

module slide_unit_checker #(
  parameter int unsigned NrLanes = 2
) (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  operand_valid_i,
  input logic                                  operand_ready_o,
  input logic                                  result_req_o,
  input logic [slide_pkg::AddrW-1:0]           result_addr_o,
  input logic [slide_pkg::ElenW*NrLanes-1:0]   result_wdata_o,
  input logic [slide_pkg::ElenW*NrLanes/8-1:0] result_be_o,
  input logic                                  result_gnt_i,
  input logic                                  done_valid_o
);

  // Failure counts, one per property
  int unsigned hold_fail    = 0;
  int unsigned be_fail      = 0;
  int unsigned operand_fail = 0;
  int unsigned done_fail    = 0;
  int unsigned fail_cnt;

  assign fail_cnt = hold_fail + be_fail + operand_fail + done_fail;

  // Pending write keeps request and fields until granted
  result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_addr_o) &&
      $stable(result_wdata_o) && $stable(result_be_o))
  else begin
    $error("Result port changed while waiting for a grant");
    hold_fail++;
  end

  // Every requested word writes at least one byte
  result_be_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o |-> result_be_o != '0)
  else begin
    $error("Result requested with all byte enables low");
    be_fail++;
  end

  // Operand only consumed when offered
  operand_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    operand_ready_o |-> operand_valid_i)
  else begin
    $error("Operand ready raised without a valid operand");
    operand_fail++;
  end

  // Completion needs a granted word one cycle earlier
  done_after_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |-> $past(result_req_o && result_gnt_i))
  else begin
    $error("Completion pulse without a grant in the previous cycle");
    done_fail++;
  end

endmodule

bind slide_unit_top slide_unit_checker #(.NrLanes(NrLanes)) u_checker (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .operand_valid_i(operand_valid_i),
  .operand_ready_o(operand_ready_o),
  .result_req_o   (result_req_o),
  .result_addr_o  (result_addr_o),
  .result_wdata_o (result_wdata_o),
  .result_be_o    (result_be_o),
  .result_gnt_i   (result_gnt_i),
  .done_valid_o   (done_valid_o)
);

//--- tb/tb_slide_unit.sv
`timescale 1ns/1ps

module tb_slide_unit;
  import slide_pkg::*;

  localparam int unsigned NrLanes     = 2;
  localparam int unsigned ResultDepth = 2;
  localparam int unsigned InsnDepth   = 2;
  localparam int unsigned W           = ElenW * NrLanes / 8;
  localparam int unsigned DataW       = ElenW * NrLanes;
  localparam int unsigned WordsPerReg = VlenB / W;
  localparam int unsigned NReq        = 16;
  // Source bytes per instruction with room for slide-down reads past the register end
  localparam int unsigned SrcB        = 160;

  logic             clk_i;
  logic             rst_ni;
  logic             req_valid_i;
  logic             req_ready_o;
  slide_op_e        req_op_i;
  vsew_e            req_vsew_i;
  logic [VlW-1:0]   req_vl_i;
  logic [VlW-1:0]   req_stride_i;
  logic [4:0]       req_vd_i;
  logic [IdW-1:0]   req_id_i;
  logic [DataW-1:0] operand_i;
  logic             operand_valid_i;
  logic             operand_ready_o;
  logic             result_req_o;
  logic [AddrW-1:0] result_addr_o;
  logic [DataW-1:0] result_wdata_o;
  logic [W-1:0]     result_be_o;
  logic             result_gnt_i;
  logic             done_valid_o;
  logic [IdW-1:0]   done_id_o;

  integer           seed;
  slide_req_t       reqs [NReq];
  // Operand stream in instruction order and expected result words in grant order
  logic [DataW-1:0] opnd_q     [$];
  logic [AddrW-1:0] exp_addr_q [$];
  logic [DataW-1:0] exp_data_q [$];
  logic [W-1:0]     exp_be_q   [$];
  logic             exp_last_q [$];
  logic [IdW-1:0]   exp_id_q   [$];

  int               req_idx;
  int               done_cnt;
  int               err_cnt;
  logic             started;
  logic             hold_gnt;
  // Handshakes seen at the falling edge and taken at the next rising edge
  logic             op_fire;
  logic             req_fire;
  logic             done_due;
  logic [IdW-1:0]   due_id;
  logic             exp_done;
  logic [IdW-1:0]   exp_done_id;
  logic [DataW-1:0] mask;

  slide_unit_top #(
    .NrLanes    (NrLanes),
    .ResultDepth(ResultDepth),
    .InsnDepth  (InsnDepth)
  ) uut (.*);

  always #10 clk_i = ~clk_i;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [DataW-1:0] be_mask(logic [W-1:0] be);
    logic [DataW-1:0] m;
    for (int b = 0; b < W; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Builds requests, their operand words and the expected result words
  task automatic build_requests();
    logic [7:0]       src [SrcB];
    logic [7:0]       dst [VlenB];
    logic             wr  [VlenB];
    logic [DataW-1:0] word;
    logic [W-1:0]     be;
    int               esz, max_el, cnt, off, first, last_w, s, n, in_off, nbytes;
    for (int i = 0; i < NReq; i++) begin
      // Each op and element width appears twice
      esz             = 1 << ((i / 2) % 4);
      max_el          = VlenB / esz;
      reqs[i].op      = (i % 2 == 1) ? op_slidedown : op_slideup;
      reqs[i].vsew    = vsew_e'(2'((i / 2) % 4));
      reqs[i].vl      = VlW'(max_el / 2 + rand_below(max_el / 2 + 1));
      reqs[i].stride  = VlW'(1 + rand_below(max_el / 4));
      reqs[i].vd      = 5'(rand_below(32));
      reqs[i].id      = IdW'(i);
      cnt             = int'(reqs[i].vl) * esz;
      off             = int'(reqs[i].stride) * esz;
      for (int b = 0; b < SrcB; b++) begin
        src[b] = 8'($random(seed));
      end
      for (int k = 0; k < VlenB; k++) begin
        dst[k] = 8'h00;
        wr[k]  = 1'b0;
      end
      if (reqs[i].op == op_slideup) begin
        for (int k = off; k < cnt; k++) begin
          dst[k] = src[k - off];
          wr[k]  = 1'b1;
        end
        first  = off / W;
        s      = 0;
        in_off = 0;
        nbytes = cnt - off;
      end else begin
        for (int k = 0; k < cnt; k++) begin
          dst[k] = src[k + off];
          wr[k]  = 1'b1;
        end
        first  = 0;
        s      = off / W;
        in_off = off % W;
        nbytes = cnt;
      end
      last_w = (cnt - 1) / W;
      for (int w = first; w <= last_w; w++) begin
        for (int b = 0; b < W; b++) begin
          word[8*b +: 8] = dst[w * W + b];
          be[b]          = wr[w * W + b];
        end
        exp_addr_q.push_back(AddrW'(int'(reqs[i].vd) * WordsPerReg + w));
        exp_data_q.push_back(word);
        exp_be_q.push_back(be);
        exp_last_q.push_back(w == last_w);
        exp_id_q.push_back(reqs[i].id);
      end
      // Source words streamed from word s onward
      n = (in_off + nbytes + W - 1) / W;
      for (int j = 0; j < n; j++) begin
        for (int b = 0; b < W; b++) begin
          word[8*b +: 8] = src[(s + j) * W + b];
        end
        opnd_q.push_back(word);
      end
    end
  endtask

  task automatic report_counts();
    $display("Errors: %0d data, %0d protocol", err_cnt, uut.u_checker.fail_cnt);
  endtask

  ////////////////////
  // Drivers
  ////////////////////

  always @(posedge clk_i) begin
    #2;
    if (started) begin
      if (op_fire) begin
        void'(opnd_q.pop_front());
      end
      if (req_fire) begin
        req_idx++;
      end
      req_valid_i = req_idx < NReq;
      if (req_idx < NReq) begin
        req_op_i     = reqs[req_idx].op;
        req_vsew_i   = reqs[req_idx].vsew;
        req_vl_i     = reqs[req_idx].vl;
        req_stride_i = reqs[req_idx].stride;
        req_vd_i     = reqs[req_idx].vd;
        req_id_i     = reqs[req_idx].id;
      end
      // Random stalls on both streams
      operand_valid_i = (opnd_q.size() != 0) && (rand_below(4) != 0);
      operand_i       = (opnd_q.size() != 0) ? opnd_q[0] : '0;
      result_gnt_i    = !hold_gnt && (rand_below(3) != 0);
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      op_fire  = 1'b0;
      req_fire = 1'b0;
      done_due = 1'b0;
    end else begin
      op_fire     = operand_valid_i && operand_ready_o;
      req_fire    = req_valid_i && req_ready_o;
      exp_done    = done_due;
      exp_done_id = due_id;
      done_due    = 1'b0;
      if (result_req_o && result_gnt_i) begin
        assert (exp_addr_q.size() != 0) else begin
          $display("Result word granted after all expected words were written");
          err_cnt++;
        end
        if (exp_addr_q.size() != 0) begin
          mask = be_mask(exp_be_q[0]);
          assert (result_addr_o == exp_addr_q[0]) else begin
            $display("MISMATCH result_addr_o: got %h expected %h", result_addr_o,
                     exp_addr_q[0]);
            err_cnt++;
          end
          assert (result_be_o == exp_be_q[0]) else begin
            $display("MISMATCH result_be_o: got %h expected %h", result_be_o, exp_be_q[0]);
            err_cnt++;
          end
          assert ((result_wdata_o & mask) == (exp_data_q[0] & mask)) else begin
            $display("MISMATCH result_wdata_o: got %h expected %h", result_wdata_o & mask,
                     exp_data_q[0] & mask);
            err_cnt++;
          end
          // Last word of an instruction arms the completion check
          if (exp_last_q[0]) begin
            done_due = 1'b1;
            due_id   = exp_id_q[0];
          end
          void'(exp_addr_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_be_q.pop_front());
          void'(exp_last_q.pop_front());
          void'(exp_id_q.pop_front());
        end
      end
      assert (done_valid_o == exp_done) else begin
        $display("MISMATCH done_valid_o: got %h expected %h", done_valid_o, exp_done);
        err_cnt++;
      end
      if (done_valid_o && exp_done) begin
        assert (done_id_o == exp_done_id) else begin
          $display("MISMATCH done_id_o: got %h expected %h", done_id_o, exp_done_id);
          err_cnt++;
        end
      end
      if (done_valid_o) begin
        done_cnt++;
      end
    end
  end

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed            = 32'h075f_85d2;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = op_slideup;
    req_vsew_i      = ew8;
    req_vl_i        = '0;
    req_stride_i    = '0;
    req_vd_i        = '0;
    req_id_i        = '0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = 1'b0;
    req_idx         = 0;
    done_cnt        = 0;
    err_cnt         = 0;
    started         = 1'b0;
    hold_gnt        = 1'b1;
    build_requests();
    repeat (10) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(negedge clk_i);
    assert (req_ready_o && !result_req_o && !operand_ready_o && !done_valid_o) else begin
      $display("Control outputs not at their idle values after reset");
      err_cnt++;
    end
    started = 1'b1;
    // Grants stay low until the queue and the result buffer fill up
    while (req_idx < InsnDepth) @(posedge clk_i);
    repeat (40) @(posedge clk_i);
    @(negedge clk_i);
    assert (!req_ready_o && result_req_o) else begin
      $display("Request port still ready with grants held low and a full queue");
      err_cnt++;
    end
    hold_gnt = 1'b0;
    while (done_cnt < NReq) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    assert (exp_addr_q.size() == 0 && opnd_q.size() == 0) else begin
      $display("Words left over at the end: %0d results, %0d operands", exp_addr_q.size(),
               opnd_q.size());
      err_cnt++;
    end
    report_counts();
    if (err_cnt == 0 && uut.u_checker.fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog allowing 200 cycles per request
  initial begin
    repeat (NReq * 200) @(posedge clk_i);
    $display("Timeout with %0d of %0d instructions complete", done_cnt, NReq);
    report_counts();
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
